/* rtl/dna_filter_pkg.sv */
`default_nettype none

package dna_filter_pkg;

    localparam int PCI_DATA_WIDTH  = 128;   // one riffa beat
    localparam int CHNL_LEN_W      = 32;    // riffa length, counted in 32-bit words
    localparam int BASES_PER_SEG   = 64;    // 2 bits per base
    localparam int BASES_PER_CYCLE = 16;
    localparam int CMP_CYCLES      = BASES_PER_SEG / BASES_PER_CYCLE;
    localparam int SLICE_W         = 2 * BASES_PER_CYCLE;   // bits compared per cycle
    localparam int PHASE_W         = $clog2(CMP_CYCLES);
    localparam int MM_COUNT_W      = $clog2(BASES_PER_SEG + 1);   // 0..64
    localparam int NUM_UNITS       = 4;     // 2 or 8 also fine
    localparam int UNIT_IDX_W      = $clog2(NUM_UNITS);
    localparam int MAX_MISMATCH    = 5;     // pass threshold, inclusive
    localparam int FIFO_DEPTH      = 16;
    localparam int FIFO_AW         = $clog2(FIFO_DEPTH);
    localparam int PAIR_W          = 2 * PCI_DATA_WIDTH;    // {read, ref}

    typedef logic [PCI_DATA_WIDTH-1:0] dna_seg_t;
    typedef logic [CHNL_LEN_W-1:0]     chnl_len_t;
    typedef logic [MM_COUNT_W-1:0]     mm_count_t;
    typedef logic [UNIT_IDX_W-1:0]     unit_idx_t;
    typedef logic [PHASE_W-1:0]        phase_t;

    typedef enum logic [1:0] {rx_idle, rx_fetch_ref, rx_processing} rx_state_t;
    typedef enum logic [1:0] {tx_idle, tx_wait_ack, tx_send} tx_state_t;

    // round-robin step, wraps at NUM_UNITS (not always a power of two)
    function automatic unit_idx_t next_unit(unit_idx_t idx);
        return (idx == unit_idx_t'(NUM_UNITS - 1)) ? '0 : idx + 1'b1;
    endfunction

endpackage

`default_nettype wire

/* rtl/pcie_recv_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module pcie_recv_fifo (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wr_en,
    input  logic [dna_filter_pkg::PAIR_W-1:0] din,
    input  logic                              rd_en,
    output logic [dna_filter_pkg::PAIR_W-1:0] dout,
    output logic                              empty,
    output logic                              almost_full
);
    logic [dna_filter_pkg::PAIR_W-1:0]  mem [dna_filter_pkg::FIFO_DEPTH];
    logic [dna_filter_pkg::FIFO_AW-1:0] wr_ptr;
    logic [dna_filter_pkg::FIFO_AW-1:0] rd_ptr;
    logic [dna_filter_pkg::FIFO_AW:0]   count;   // one extra bit, holds FIFO_DEPTH
    logic                               do_wr;
    logic                               do_rd;

    assign do_wr = wr_en && (count != dna_filter_pkg::FIFO_DEPTH);   // drop on overflow
    assign do_rd = rd_en && !empty;

    assign dout  = mem[rd_ptr];   // head shows without a read, fwft
    assign empty = (count == 0);

    // read enable upstream reacts a cycle late, so leave room for one more beat
    assign almost_full = (count >= dna_filter_pkg::FIFO_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps itself
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/pcie_data_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module pcie_data_receiver (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              chnl_rx,
    input  dna_filter_pkg::chnl_len_t         chnl_rx_len,
    input  dna_filter_pkg::dna_seg_t          chnl_rx_data,
    input  logic                              chnl_rx_data_valid,
    input  logic                              sender_ready,
    input  logic                              fifo_almost_full,
    output logic                              chnl_rx_ack,
    output logic                              chnl_rx_data_ren,
    output logic                              fifo_wr,
    output logic [dna_filter_pkg::PAIR_W-1:0] fifo_din,
    output logic                              sender_en,
    output dna_filter_pkg::chnl_len_t         pair_count
);
    dna_filter_pkg::rx_state_t state;
    dna_filter_pkg::chnl_len_t beats_left;   // beats still due, current one included
    dna_filter_pkg::dna_seg_t  ref_r;
    dna_filter_pkg::dna_seg_t  read_r;
    logic                      accept;
    logic                      beat;

    // only take a new transaction once the previous results are out
    assign accept = (state == dna_filter_pkg::rx_idle) && chnl_rx && sender_ready;

    assign chnl_rx_data_ren = (state != dna_filter_pkg::rx_idle) && !fifo_almost_full;
    assign beat             = chnl_rx_data_valid && chnl_rx_data_ren;
    assign fifo_din         = {read_r, ref_r};   // read in upper half

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= dna_filter_pkg::rx_idle;
            chnl_rx_ack <= 1'b0;
            sender_en   <= 1'b0;
            fifo_wr     <= 1'b0;
            beats_left  <= '0;
        end else begin
            chnl_rx_ack <= 1'b0;   // pulses
            sender_en   <= 1'b0;
            fifo_wr     <= 1'b0;
            case (state)
                dna_filter_pkg::rx_idle: begin
                    if (accept) begin
                        chnl_rx_ack <= 1'b1;
                        sender_en   <= 1'b1;
                        beats_left  <= chnl_rx_len >> 2;   // 4 words per beat
                        state       <= dna_filter_pkg::rx_fetch_ref;
                    end
                end
                dna_filter_pkg::rx_fetch_ref: begin
                    if (beat) begin
                        beats_left <= beats_left - 1'b1;
                        // reference-only transaction ends right here
                        state <= (beats_left == 1) ? dna_filter_pkg::rx_idle
                                                   : dna_filter_pkg::rx_processing;
                    end
                end
                dna_filter_pkg::rx_processing: begin
                    if (beat) begin
                        fifo_wr    <= 1'b1;   // read_r lands this edge, push next cycle
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == 1)
                            state <= dna_filter_pkg::rx_idle;
                    end
                end
                default: state <= dna_filter_pkg::rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            pair_count <= (chnl_rx_len >> 2) - 1'b1;   // minus the reference beat
        if (beat && state == dna_filter_pkg::rx_fetch_ref)
            ref_r <= chnl_rx_data;   // held for the whole transaction
        if (beat && state == dna_filter_pkg::rx_processing)
            read_r <= chnl_rx_data;
    end

endmodule

`default_nettype wire

/* rtl/filter_dispatcher.sv */
`timescale 1ns/10ps
`default_nettype none

module filter_dispatcher (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fifo_empty,
    input  logic [dna_filter_pkg::PAIR_W-1:0]    fifo_dout,
    input  logic [dna_filter_pkg::NUM_UNITS-1:0] unit_busy,
    output logic                                 fifo_rd,
    output logic [dna_filter_pkg::NUM_UNITS-1:0] unit_start,
    output dna_filter_pkg::dna_seg_t             seg_read,
    output dna_filter_pkg::dna_seg_t             seg_ref
);
    dna_filter_pkg::unit_idx_t ptr;   // next unit in turn

    // strict order, never skip a busy unit, the sender walks the same sequence
    assign fifo_rd = !fifo_empty && !unit_busy[ptr];

    // head word goes straight to the units, only the started one captures it
    assign seg_read = fifo_dout[dna_filter_pkg::PAIR_W-1 -: dna_filter_pkg::PCI_DATA_WIDTH];
    assign seg_ref  = fifo_dout[dna_filter_pkg::PCI_DATA_WIDTH-1:0];

    always_comb begin
        unit_start      = '0;
        unit_start[ptr] = fifo_rd;   // start in the pop cycle
    end

    always_ff @(posedge clk) begin
        if (rst)
            ptr <= '0;
        else if (fifo_rd)
            ptr <= dna_filter_pkg::next_unit(ptr);
    end

endmodule

`default_nettype wire

/* rtl/mismatch_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module mismatch_filter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  dna_filter_pkg::dna_seg_t  seg_read,
    input  dna_filter_pkg::dna_seg_t  seg_ref,
    input  logic                      res_ack,
    output logic                      busy,
    output logic                      res_valid,
    output dna_filter_pkg::mm_count_t res_count,
    output logic                      res_pass
);
    dna_filter_pkg::dna_seg_t             read_r;   // shifted down a slice per cycle
    dna_filter_pkg::dna_seg_t             ref_r;
    dna_filter_pkg::dna_seg_t             cmp_read;
    dna_filter_pkg::dna_seg_t             cmp_ref;
    logic [dna_filter_pkg::SLICE_W-1:0]   diff;
    dna_filter_pkg::mm_count_t            slice_cnt;
    dna_filter_pkg::phase_t               phase;
    logic                                 load;
    logic                                 step;

    assign load = start && !busy;
    assign step = load || (busy && !res_valid);

    // first slice is compared straight off the inputs, saves a cycle
    assign cmp_read = load ? seg_read : read_r;
    assign cmp_ref  = load ? seg_ref : ref_r;
    assign diff     = cmp_read[dna_filter_pkg::SLICE_W-1:0] ^ cmp_ref[dna_filter_pkg::SLICE_W-1:0];

    assign res_pass = (res_count <= dna_filter_pkg::MAX_MISMATCH);

    always_comb begin
        slice_cnt = '0;
        for (int i = 0; i < dna_filter_pkg::BASES_PER_CYCLE; i++)
            slice_cnt = slice_cnt + (diff[2*i] | diff[2*i+1]);   // base differs if either bit
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            res_valid <= 1'b0;
            phase     <= '0;
        end else begin
            if (res_ack) begin
                busy      <= 1'b0;
                res_valid <= 1'b0;
            end
            if (load) begin
                busy  <= 1'b1;
                phase <= dna_filter_pkg::phase_t'(1);   // slice 0 done at load
            end else if (step) begin
                phase <= phase + 1'b1;   // wraps back to 0 after the last slice
                if (phase == dna_filter_pkg::CMP_CYCLES - 1)
                    res_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            read_r    <= cmp_read >> dna_filter_pkg::SLICE_W;
            ref_r     <= cmp_ref >> dna_filter_pkg::SLICE_W;
            res_count <= (load ? '0 : res_count) + slice_cnt;
        end
    end

endmodule

`default_nettype wire

/* rtl/pcie_result_sender.sv */
`timescale 1ns/10ps
`default_nettype none

module pcie_result_sender (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            sender_en,
    input  dna_filter_pkg::chnl_len_t                       pair_count,
    input  logic [dna_filter_pkg::NUM_UNITS-1:0]            res_valid,
    input  dna_filter_pkg::mm_count_t [dna_filter_pkg::NUM_UNITS-1:0] res_count,
    input  logic [dna_filter_pkg::NUM_UNITS-1:0]            res_pass,
    input  logic                                            chnl_tx_ack,
    input  logic                                            chnl_tx_data_ren,
    output logic                                            sender_ready,
    output logic [dna_filter_pkg::NUM_UNITS-1:0]            res_ack,
    output logic                                            chnl_tx,
    output logic                                            chnl_tx_last,
    output dna_filter_pkg::chnl_len_t                       chnl_tx_len,
    output dna_filter_pkg::dna_seg_t                        chnl_tx_data,
    output logic                                            chnl_tx_data_valid
);
    dna_filter_pkg::tx_state_t state;
    dna_filter_pkg::unit_idx_t ptr;          // tracks the dispatcher's order
    dna_filter_pkg::chnl_len_t words_left;
    logic                      word_done;
    logic                      load_word;

    assign sender_ready = (state == dna_filter_pkg::tx_idle);
    assign chnl_tx_last = 1'b1;   // one tx transaction per rx transaction
    assign word_done    = chnl_tx_data_valid && chnl_tx_data_ren;
    assign load_word    = (state == dna_filter_pkg::tx_send) && !chnl_tx_data_valid
                          && res_valid[ptr];

    always_comb begin
        res_ack      = '0;
        res_ack[ptr] = word_done;   // frees the unit on the transfer edge
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= dna_filter_pkg::tx_idle;
            chnl_tx            <= 1'b0;
            chnl_tx_data_valid <= 1'b0;
            ptr                <= '0;
            words_left         <= '0;
        end else begin
            case (state)
                dna_filter_pkg::tx_idle: begin
                    if (sender_en) begin
                        words_left <= pair_count;
                        chnl_tx    <= 1'b1;
                        state      <= dna_filter_pkg::tx_wait_ack;
                    end
                end
                dna_filter_pkg::tx_wait_ack: begin
                    if (chnl_tx_ack) begin
                        if (words_left == 0) begin   // no reads, nothing to send
                            chnl_tx <= 1'b0;
                            state   <= dna_filter_pkg::tx_idle;
                        end else begin
                            state <= dna_filter_pkg::tx_send;
                        end
                    end
                end
                dna_filter_pkg::tx_send: begin
                    if (word_done) begin
                        chnl_tx_data_valid <= 1'b0;
                        ptr                <= dna_filter_pkg::next_unit(ptr);
                        words_left         <= words_left - 1'b1;
                        if (words_left == 1) begin
                            chnl_tx <= 1'b0;
                            state   <= dna_filter_pkg::tx_idle;
                        end
                    end else if (load_word) begin
                        chnl_tx_data_valid <= 1'b1;   // held until host takes it
                    end
                end
                default: state <= dna_filter_pkg::tx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sender_en && state == dna_filter_pkg::tx_idle)
            chnl_tx_len <= pair_count << 2;   // 4 words per result
        if (load_word)   // count in 6..0, pass in 7, rest zero
            chnl_tx_data <= dna_filter_pkg::dna_seg_t'({res_pass[ptr], res_count[ptr]});
    end

endmodule

`default_nettype wire

/* rtl/dna_filter_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dna_filter_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      chnl_rx,
    input  dna_filter_pkg::chnl_len_t chnl_rx_len,
    input  dna_filter_pkg::dna_seg_t  chnl_rx_data,
    input  logic                      chnl_rx_data_valid,
    output logic                      chnl_rx_ack,
    output logic                      chnl_rx_data_ren,
    output logic                      chnl_tx,
    output logic                      chnl_tx_last,
    output dna_filter_pkg::chnl_len_t chnl_tx_len,
    output dna_filter_pkg::dna_seg_t  chnl_tx_data,
    output logic                      chnl_tx_data_valid,
    input  logic                      chnl_tx_ack,
    input  logic                      chnl_tx_data_ren
);
    logic                                     sender_ready;
    logic                                     sender_en;
    dna_filter_pkg::chnl_len_t                pair_count;
    logic                                     fifo_wr;
    logic [dna_filter_pkg::PAIR_W-1:0]        fifo_din;
    logic                                     fifo_rd;
    logic [dna_filter_pkg::PAIR_W-1:0]        fifo_dout;
    logic                                     fifo_empty;
    logic                                     fifo_almost_full;
    logic [dna_filter_pkg::NUM_UNITS-1:0]     unit_start;
    logic [dna_filter_pkg::NUM_UNITS-1:0]     unit_busy;
    dna_filter_pkg::dna_seg_t                 seg_read;   // shared by all units
    dna_filter_pkg::dna_seg_t                 seg_ref;
    logic [dna_filter_pkg::NUM_UNITS-1:0]     res_valid;
    dna_filter_pkg::mm_count_t [dna_filter_pkg::NUM_UNITS-1:0] res_count;
    logic [dna_filter_pkg::NUM_UNITS-1:0]     res_pass;
    logic [dna_filter_pkg::NUM_UNITS-1:0]     res_ack;

    pcie_data_receiver recv0 (.*);   // port names match the nets here

    pcie_recv_fifo fifo0 (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (fifo_wr),
        .din         (fifo_din),
        .rd_en       (fifo_rd),
        .dout        (fifo_dout),
        .empty       (fifo_empty),
        .almost_full (fifo_almost_full)
    );

    filter_dispatcher disp0 (.*);

    for (genvar i = 0; i < dna_filter_pkg::NUM_UNITS; i++) begin : unit_gen
        mismatch_filter filt (
            .clk       (clk),
            .rst       (rst),
            .start     (unit_start[i]),
            .seg_read  (seg_read),
            .seg_ref   (seg_ref),
            .res_ack   (res_ack[i]),
            .busy      (unit_busy[i]),
            .res_valid (res_valid[i]),
            .res_count (res_count[i]),
            .res_pass  (res_pass[i])
        );
    end

    pcie_result_sender send0 (.*);

endmodule

`default_nettype wire

/* verification/dna_filter_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module dna_filter_tb;

    localparam int          TOTAL_PAIRS    = 3 + 20 + 5 + 40 + 12;   // reads over all tests
    localparam int          TIMEOUT_CYCLES = 200 * TOTAL_PAIRS + 2000;
    localparam logic [31:0] SEED           = 32'h746406bf;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      chnl_rx;
    dna_filter_pkg::chnl_len_t chnl_rx_len;
    dna_filter_pkg::dna_seg_t  chnl_rx_data;
    logic                      chnl_rx_data_valid;
    logic                      chnl_rx_ack;
    logic                      chnl_rx_data_ren;
    logic                      chnl_tx;
    logic                      chnl_tx_last;
    dna_filter_pkg::chnl_len_t chnl_tx_len;
    dna_filter_pkg::dna_seg_t  chnl_tx_data;
    logic                      chnl_tx_data_valid;
    logic                      chnl_tx_ack;
    logic                      chnl_tx_data_ren;

    dna_filter_pkg::dna_seg_t  read_q [$];   // reads of the next rx transaction
    dna_filter_pkg::dna_seg_t  exp_q [$];    // expected result words, arrival order
    int                        len_q [$];    // read count per rx transaction
    logic [31:0]               data_lfsr;
    logic [31:0]               stall_lfsr;   // separate stream for tx back-pressure
    int                        val_errs;
    int                        proto_errs;
    int                        cycles;
    int                        rx_acks;
    int                        tx_closed;
    int                        words_got;
    int                        words_due;
    int                        last_words;
    logic                      tx_open;
    logic                      ack_due;
    logic                      rx_stalled;
    logic                      bp_on;
    logic                      bp_high;
    int                        bp_run;

    always #10 clk = ~clk;   // 20 ns period

    dna_filter_top dut0 (
        .clk                (clk),
        .rst                (rst),
        .chnl_rx            (chnl_rx),
        .chnl_rx_len        (chnl_rx_len),
        .chnl_rx_data       (chnl_rx_data),
        .chnl_rx_data_valid (chnl_rx_data_valid),
        .chnl_rx_ack        (chnl_rx_ack),
        .chnl_rx_data_ren   (chnl_rx_data_ren),
        .chnl_tx            (chnl_tx),
        .chnl_tx_last       (chnl_tx_last),
        .chnl_tx_len        (chnl_tx_len),
        .chnl_tx_data       (chnl_tx_data),
        .chnl_tx_data_valid (chnl_tx_data_valid),
        .chnl_tx_ack        (chnl_tx_ack),
        .chnl_tx_data_ren   (chnl_tx_data_ren)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            data_lfsr = lfsr_next(data_lfsr);   // one step per bit
            r = {r[30:0], data_lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] stall_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            r = {r[30:0], stall_lfsr[0]};
        end
        return r;
    endfunction

    function automatic dna_filter_pkg::dna_seg_t random_seg();
        dna_filter_pkg::dna_seg_t s;
        int                       w;
        for (w = 0; w < dna_filter_pkg::PCI_DATA_WIDTH / 32; w++)
            s[32*w +: 32] = take_bits(32);
        return s;
    endfunction

    // flips n bases at random spots, repeats may land on one base
    function automatic dna_filter_pkg::dna_seg_t inject_mismatches(
        input dna_filter_pkg::dna_seg_t rf,
        input int n
    );
        dna_filter_pkg::dna_seg_t rd;
        logic [31:0]              flip;
        int                       p;
        int                       k;
        rd = rf;
        for (k = 0; k < n; k++) begin
            p    = take_bits(6);
            flip = take_bits(2);
            if (flip[1:0] == 2'b00)
                flip = 32'd3;   // xor by zero keeps the base
            rd[2*p +: 2] = rd[2*p +: 2] ^ flip[1:0];
        end
        return rd;
    endfunction

    // golden model, result word is count in 6..0 and pass in 7
    function automatic dna_filter_pkg::dna_seg_t expected_word(
        input dna_filter_pkg::dna_seg_t rd,
        input dna_filter_pkg::dna_seg_t rf
    );
        dna_filter_pkg::dna_seg_t w;
        int                       cnt;
        int                       b;
        cnt = 0;
        for (b = 0; b < dna_filter_pkg::BASES_PER_SEG; b++)
            if (rd[2*b +: 2] != rf[2*b +: 2])
                cnt++;
        w      = '0;
        w[6:0] = cnt[6:0];
        w[7]   = (cnt <= dna_filter_pkg::MAX_MISMATCH);
        return w;
    endfunction

    task automatic check_seg(input string name, input dna_filter_pkg::dna_seg_t exp,
                             input dna_filter_pkg::dna_seg_t got);
        if (got !== exp) begin
            val_errs++;
            $display("Fail %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_len(input string name, input dna_filter_pkg::chnl_len_t exp,
                             input dna_filter_pkg::chnl_len_t got);
        if (got !== exp) begin
            val_errs++;
            $display("Fail %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            val_errs++;
            $display("Fail %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic protocol_error(input string msg);
        proto_errs++;
        $display("protocol error at %0t: %s", $time, msg);
    endtask

    task automatic finish_run(input logic timed_out);
        $display("value errors %0d, protocol errors %0d", val_errs, proto_errs);
        if (!timed_out && val_errs == 0 && proto_errs == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    // rx host, reference beat then every read in read_q
    task automatic send_rx_txn(input dna_filter_pkg::dna_seg_t ref_seg);
        int   n;
        int   idx;
        logic took;
        n          = read_q.size();
        rx_stalled = 1'b0;
        for (idx = 0; idx < n; idx++)
            exp_q.push_back(expected_word(read_q[idx], ref_seg));
        len_q.push_back(n);
        @(posedge clk);
        chnl_rx     <= 1'b1;
        chnl_rx_len <= dna_filter_pkg::chnl_len_t'((n + 1) * 4);
        do
            @(negedge clk);
        while (!chnl_rx_ack);
        if (tx_closed != rx_acks)
            protocol_error("rx transaction acknowledged while earlier results were pending");
        rx_acks++;
        idx = 0;
        @(posedge clk);
        chnl_rx_data_valid <= 1'b1;
        chnl_rx_data       <= ref_seg;
        while (idx < n + 1) begin
            @(negedge clk);
            took = chnl_rx_data_ren;   // valid is high, so ren decides the transfer
            if (!took)
                rx_stalled = 1'b1;
            @(posedge clk);
            if (took) begin
                idx++;
                if (idx < n + 1) begin
                    chnl_rx_data <= read_q[idx-1];
                end else begin
                    chnl_rx_data_valid <= 1'b0;
                    chnl_rx            <= 1'b0;
                end
            end
        end
        read_q.delete();
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || tx_closed != rx_acks)
            @(posedge clk);
    endtask

    task automatic set_back_pressure(input logic on);
        @(negedge clk);
        bp_on = on;
    endtask

    // tx host, samples at negedge and drives at posedge
    always begin : tx_host
        dna_filter_pkg::dna_seg_t want;
        int                       nbits;
        @(negedge clk);
        if (!rst) begin
            if (chnl_tx_data_valid && chnl_tx_data_ren) begin
                words_got++;
                if (!tx_open) begin
                    protocol_error("result word transferred outside a tx transaction");
                end else if (exp_q.size() == 0) begin
                    protocol_error("result word transferred with no result expected");
                end else begin
                    want = exp_q.pop_front();
                    check_seg("chnl_tx_data", want, chnl_tx_data);
                end
            end
            if (chnl_tx && !tx_open) begin
                tx_open   = 1'b1;
                ack_due   = 1'b1;
                words_got = 0;
                words_due = 0;
                if (len_q.size() == 0)
                    protocol_error("tx transaction opened with no rx transaction sent");
                else
                    words_due = len_q.pop_front();
                check_len("chnl_tx_len", dna_filter_pkg::chnl_len_t'(words_due * 4), chnl_tx_len);
                check_bit("chnl_tx_last", 1'b1, chnl_tx_last);
            end else if (!chnl_tx && tx_open) begin
                tx_open    = 1'b0;
                last_words = words_got;
                tx_closed++;
                if (words_got != words_due)
                    protocol_error("tx transaction ended with missing or extra words");
            end
        end
        @(posedge clk);
        chnl_tx_ack <= ack_due;   // one cycle pulse
        ack_due = 1'b0;
        if (bp_on) begin
            if (bp_run == 0) begin
                bp_high = !bp_high;
                nbits   = bp_high ? 2 : 5;
                bp_run  = bp_high ? 1 + stall_bits(nbits) : 16 + stall_bits(nbits);   // long lows
            end
            bp_run--;
            chnl_tx_data_ren <= bp_high;
        end else begin
            chnl_tx_data_ren <= 1'b1;
        end
    end

    task automatic identical_reads();
        dna_filter_pkg::dna_seg_t ref_seg;
        int                       i;
        check_bit("chnl_rx_ack", 1'b0, chnl_rx_ack);
        check_bit("chnl_rx_data_ren", 1'b0, chnl_rx_data_ren);
        check_bit("chnl_tx", 1'b0, chnl_tx);
        check_bit("chnl_tx_data_valid", 1'b0, chnl_tx_data_valid);
        ref_seg = random_seg();
        for (i = 0; i < 3; i++)
            read_q.push_back(ref_seg);   // count 0, pass set
        send_rx_txn(ref_seg);
        wait_drained();
    endtask

    task automatic random_reads(input int n, input int max_mm);
        dna_filter_pkg::dna_seg_t ref_seg;
        int                       i;
        ref_seg = random_seg();
        for (i = 0; i < n; i++)
            read_q.push_back(inject_mismatches(ref_seg, take_bits(4) % (max_mm + 1)));
        send_rx_txn(ref_seg);
        wait_drained();
    endtask

    task automatic length_fields();
        random_reads(5, 12);
        check_len("tx word count", dna_filter_pkg::chnl_len_t'(5),
                  dna_filter_pkg::chnl_len_t'(last_words));
    endtask

    task automatic tx_back_pressure();
        set_back_pressure(1'b1);
        random_reads(40, 12);
        if (!rx_stalled)
            protocol_error("chnl_rx_data_ren never dropped while tx was stalled");
        set_back_pressure(1'b0);
    endtask

    task automatic back_to_back_txns();
        dna_filter_pkg::dna_seg_t ref_a;
        dna_filter_pkg::dna_seg_t ref_b;
        int                       i;
        ref_a = random_seg();
        ref_b = random_seg();
        for (i = 0; i < 6; i++)
            read_q.push_back(inject_mismatches(ref_a, take_bits(3)));
        send_rx_txn(ref_a);
        for (i = 0; i < 6; i++)
            read_q.push_back(inject_mismatches(ref_b, take_bits(3)));   // near ref_b only
        send_rx_txn(ref_b);   // held off until the first results are out
        wait_drained();
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, results still outstanding", cycles);
        finish_run(1'b1);
    end

    initial begin : main
        rst                = 1'b1;
        chnl_rx            = 1'b0;
        chnl_rx_len        = '0;
        chnl_rx_data       = '0;
        chnl_rx_data_valid = 1'b0;
        chnl_tx_ack        = 1'b0;
        chnl_tx_data_ren   = 1'b0;
        data_lfsr          = SEED;
        stall_lfsr         = SEED;
        val_errs           = 0;
        proto_errs         = 0;
        rx_acks            = 0;
        tx_closed          = 0;
        words_got          = 0;
        words_due          = 0;
        last_words         = 0;
        tx_open            = 1'b0;
        ack_due            = 1'b0;
        rx_stalled         = 1'b0;
        bp_on              = 1'b0;
        bp_high            = 1'b0;
        bp_run             = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        identical_reads();
        random_reads(20, 12);   // wraps the unit pointer several times
        length_fields();
        tx_back_pressure();
        back_to_back_txns();
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

/* filelist.f */
rtl/dna_filter_pkg.sv
rtl/pcie_recv_fifo.sv
rtl/pcie_data_receiver.sv
rtl/filter_dispatcher.sv
rtl/mismatch_filter.sv
rtl/pcie_result_sender.sv
rtl/dna_filter_top.sv
verification/dna_filter_tb.sv

/* Bender.yml */
package:
  name: dna_filter

sources:
  - files:
      - rtl/dna_filter_pkg.sv
      - rtl/pcie_recv_fifo.sv
      - rtl/pcie_data_receiver.sv
      - rtl/filter_dispatcher.sv
      - rtl/mismatch_filter.sv
      - rtl/pcie_result_sender.sv
      - rtl/dna_filter_top.sv
  - target: test
    files:
      - verification/dna_filter_tb.sv
